//--- design/coef_rom.sv
/*
 * Coefficient store for all lanes
 * Registered weights per channel address, constant biases
 */
`timescale 1ns/10ps
`include "squeeze_params.svh"

module coef_rom import squeeze_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  chan_addr_t addr,
	output pix_t       weights [`SQZ_LANES],
	output acc_t       biases [`SQZ_LANES]
);

	// Flat weight table, one row per lane
	pix_t w_tab [`SQZ_LANES][`SQZ_CHIN];

	genvar l, c;
	generate
		for (l = 0; l < `SQZ_LANES; l++) begin : g_lane
			for (c = 0; c < `SQZ_CHIN; c++) begin : g_chan
				assign w_tab[l][c] = weight_of(l, c);
			end
			// Biases never change during a layer
			assign biases[l] = bias_of(l);
		end
	endgenerate

	//////////////////////////////////////////////////
	// Weight read register
	//////////////////////////////////////////////////
	// One cycle read, lines up with the second pixel delay stage
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `SQZ_LANES; i++) begin
				weights[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `SQZ_LANES; i++) begin
				weights[i] <= w_tab[i][addr];
			end
		end
	end

endmodule

//--- design/mac_lane.sv
/*
 * Single signed multiply-accumulate lane
 * Clear pulse restarts the sum from the current product
 */
`timescale 1ns/10ps

module mac_lane import squeeze_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic clr,
	input  logic lane_en,
	input  pix_t pix,
	input  pix_t weight,
	output acc_t sum
);

	// Full precision product
	acc_t prod;

	// Both operands signed, result sign extended to 2x width
	assign prod = pix * weight;

	//////////////////////////////////////////////////
	// Accumulator
	//////////////////////////////////////////////////
	// clr marks the cycle where sum holds a finished pixel
	// The first channel of the next pixel may already be here
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sum <= '0;
		end else if (clr) begin
			// Start next pixel, no cycle lost
			if (lane_en) begin
				sum <= prod;
			end else begin
				sum <= '0;
			end
		end else if (lane_en) begin
			sum <= sum + prod;
		end
		// Otherwise hold during input pauses
	end

endmodule

//--- design/requant.sv
/*
 * Output stage, bias add, ReLU and slicing back to pixel width
 * Registers the vector on clr and raises sample
 */
`timescale 1ns/10ps
`include "squeeze_params.svh"

module requant import squeeze_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic clr,
	input  acc_t sums [`SQZ_LANES],
	input  acc_t biases [`SQZ_LANES],
	output pix_t ofm [`SQZ_LANES],
	output logic sample
);

	acc_t biased [`SQZ_LANES];
	pix_t q      [`SQZ_LANES];

	//////////////////////////////////////////////////
	// Bias, ReLU, slice
	//////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < `SQZ_LANES; i++) begin
			biased[i] = sums[i] + biases[i];
			// Negative result clamps to zero
			if (biased[i][2*`SQZ_WIDTH-1]) begin
				q[i] = '0;
			end else begin
				// Sign forced low, upper bits dropped
				q[i] = {1'b0, biased[i][`SQZ_FRAC+`SQZ_WIDTH-2:`SQZ_FRAC]};
			end
		end
	end

	// Output vector, only loaded when a pixel completes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `SQZ_LANES; i++) begin
				ofm[i] <= '0;
			end
		end else if (clr) begin
			ofm <= q;
		end
	end

	// Strobe in the same cycle as the new vector
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sample <= 1'b0;
		end else begin
			sample <= clr;
		end
	end

endmodule

//--- design/squeeze_ctrl.sv
/*
 * Sequencer for the squeeze stage
 * Input delay line, channel address, clear pulse, pixel count, layer done
 */
`timescale 1ns/10ps
`include "squeeze_params.svh"

module squeeze_ctrl import squeeze_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       en,
	input  pix_t       ifm,
	input  logic       ram_feedback,
	output pix_t       pix_d,
	output logic       lane_en,
	output chan_addr_t addr,
	output logic       clr,
	output logic       finish
);

	// Pixels in one layer
	localparam int NPIX   = `SQZ_WOUT * `SQZ_WOUT;
	localparam int PIX_CW = $clog2(NPIX + 1);
	// Address of the final channel of a pixel
	localparam chan_addr_t LAST_CHAN = chan_addr_t'(`SQZ_CHIN - 1);

	// First delay stage
	logic en_d1;
	pix_t pix_d1;

	// Channel wrap seen, one cycle ahead of clr
	logic wrap;
	logic last_chan;

	// Layer progress
	logic [PIX_CW-1:0] pix_cnt;
	logic              layer_end;
	logic              fb_seen;

	//////////////////////////////////////////////////
	// Enable and pixel delay line
	//////////////////////////////////////////////////
	// Two stages so data meets the registered weight
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			en_d1   <= 1'b0;
			lane_en <= 1'b0;
		end else begin
			en_d1   <= en;
			lane_en <= en_d1;
		end
	end

	// Pixel delay stages
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pix_d1 <= '0;
			pix_d  <= '0;
		end else begin
			pix_d1 <= ifm;
			pix_d  <= pix_d1;
		end
	end

	//////////////////////////////////////////////////
	// Channel address counter
	//////////////////////////////////////////////////
	// Address moves with the first delay stage
	// so coef_rom output lands with pix_d
	assign last_chan = en_d1 && (addr == LAST_CHAN);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			addr <= '0;
		end else if (last_chan) begin
			// Back to channel zero for the next pixel
			addr <= '0;
		end else if (en_d1) begin
			addr <= addr + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Clear pulse
	//////////////////////////////////////////////////
	// wrap goes high as the last channel enters the lanes
	// clr follows one cycle later, once that product is in the sum
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wrap <= 1'b0;
			clr  <= 1'b0;
		end else begin
			wrap <= last_chan;
			clr  <= wrap;
		end
	end

	//////////////////////////////////////////////////
	// Pixel counter and layer end
	//////////////////////////////////////////////////
	// Counts clear pulses, saturates at the end of the map
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pix_cnt   <= '0;
			layer_end <= 1'b0;
		end else if (clr && !layer_end) begin
			pix_cnt <= pix_cnt + 1'b1;
			// Last pixel of the map
			if (pix_cnt == PIX_CW'(NPIX - 1)) begin
				layer_end <= 1'b1;
			end
		end
	end

	// Sticky ack from downstream memory
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fb_seen <= 1'b0;
		end else if (ram_feedback) begin
			fb_seen <= 1'b1;
		end
	end

	// Done until memory acks, then low until next reset
	assign finish = layer_end && !fb_seen;

endmodule

//--- design/squeeze_params.svh
/*
 * Sizing macros for the fire squeeze stage
 * Pixel width, lane count, channel count, map width, requant shift
 */
`ifndef SQUEEZE_PARAMS_SVH
`define SQUEEZE_PARAMS_SVH

// Pixel and weight width in bits
`define SQZ_WIDTH 16

// Parallel output channels, one MAC lane each
`define SQZ_LANES 4

// Input channels summed per output pixel
`define SQZ_CHIN 8

// Output map is SQZ_WOUT x SQZ_WOUT pixels
`define SQZ_WOUT 3

// Fraction bits dropped when going back to pixel width
`define SQZ_FRAC 14

`endif

//--- design/squeeze_pkg.sv
/*
 * Shared types for the squeeze stage
 * Coefficient formulas for weights and biases
 */
`include "squeeze_params.svh"

package squeeze_pkg;

	// Address width, never below one bit
	localparam int CHAN_AW = (`SQZ_CHIN > 1) ? $clog2(`SQZ_CHIN) : 1;

	typedef logic signed [`SQZ_WIDTH-1:0]   pix_t;
	typedef logic signed [2*`SQZ_WIDTH-1:0] acc_t;
	typedef logic [CHAN_AW-1:0]             chan_addr_t;

	// Weight in Q2.14, small multiples of 1/16
	function automatic pix_t weight_of(input int lane, input int chan);
		int raw;
		raw = ((lane * 7 + chan * 3 + 2) % 13) - 6;
		return pix_t'(raw * 1024);
	endfunction

	// Bias already aligned to the accumulator fraction
	function automatic acc_t bias_of(input int lane);
		int raw;
		raw = ((lane * 5 + 1) % 7) - 3;
		return acc_t'(raw * 4 * (1 << `SQZ_FRAC));
	endfunction

endpackage

//--- design/squeeze_top.sv
/*
 * Squeeze stage top level
 * Controller, coefficient store, lane array and requantiser
 */
`timescale 1ns/10ps
`include "squeeze_params.svh"

module squeeze_top import squeeze_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic en,
	input  pix_t ifm,
	input  logic ram_feedback,
	output pix_t ofm [`SQZ_LANES],
	output logic sample,
	output logic finish
);

	pix_t       pix_d;
	logic       lane_en;
	chan_addr_t addr;
	logic       clr;
	pix_t       weights [`SQZ_LANES];
	acc_t       biases  [`SQZ_LANES];
	acc_t       sums    [`SQZ_LANES];

	squeeze_ctrl ctrl_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.en           (en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.pix_d        (pix_d),
		.lane_en      (lane_en),
		.addr         (addr),
		.clr          (clr),
		.finish       (finish)
	);

	coef_rom rom_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.addr    (addr),
		.weights (weights),
		.biases  (biases)
	);

	// One lane per output channel, all share the pixel
	genvar l;
	generate
		for (l = 0; l < `SQZ_LANES; l++) begin : g_mac
			mac_lane mac_i (
				.clk     (clk),
				.arst_n  (arst_n),
				.clr     (clr),
				.lane_en (lane_en),
				.pix     (pix_d),
				.weight  (weights[l]),
				.sum     (sums[l])
			);
		end
	endgenerate

	requant rq_i (
		.clk    (clk),
		.arst_n (arst_n),
		.clr    (clr),
		.sums   (sums),
		.biases (biases),
		.ofm    (ofm),
		.sample (sample)
	);

endmodule

//--- sim/squeeze_trace.txt
// Squeeze stage trace in hex, one output pixel per line
// Columns: ifm for channels 0..7, then expected ofm for lanes 0..3
// Ramp input, mixed signs before ReLU
0064 00C8 012C 0190 01F4 0258 02BC 0320  0081 0000 016E 0000
// All zero input, bias only
0000 0000 0000 0000 0000 0000 0000 0000  0000 000C 0004 0000
// Constant negative input
FC18 FC18 FC18 FC18 FC18 FC18 FC18 FC18  0000 0000 0000 003A
// Large values, upper bits truncated on lanes 0 and 2
B1E0 0000 7530 7FFF 8AD0 D8F0 61A8 7D00  1901 0000 27A4 0000
// Every lane negative
0010 FFF0 0020 FFE0 0030 FFD0 0040 FFC0  0000 0000 0000 0000
// Constant positive input
03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8  0000 0106 01F8 0000
// Single channel set
1388 0000 0000 0000 0000 0000 0000 0000  0000 03B5 0000 04DE
// Two channels, rounding toward minus infinity
0000 0000 0000 0BB8 0000 0000 0000 F830  01AD 004A 01F8 0079
// Small mixed values
0007 FFFD 000C FFF7 0015 0005 FFEF 0002  0000 0013 0000 0006

//--- sim/tb_squeeze.sv
/*
 * Trace-driven testbench for the squeeze stage
 * Clock, reset, stimulus, output checker, layer-done test, watchdog
 */
`timescale 1ns/10ps
`include "squeeze_params.svh"

module tb_squeeze import squeeze_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int NPIX       = `SQZ_WOUT * `SQZ_WOUT;
	// Words per trace line, inputs then expected lanes
	localparam int REC        = `SQZ_CHIN + `SQZ_LANES;
	// Longest random pause between two channels
	localparam int MAX_GAP    = 3;
	// Two layers at worst-case gaps, plus resets, idle and done checks
	localparam int TIMEOUT_CYC = 2 * NPIX * `SQZ_CHIN * (MAX_GAP + 1) + 400;

	logic clk;
	logic arst_n;
	logic en;
	pix_t ifm;
	logic ram_feedback;
	pix_t ofm [`SQZ_LANES];
	logic sample;
	logic finish;

	// Trace image, one REC-word record per output pixel
	logic [`SQZ_WIDTH-1:0] trace_mem [0:NPIX*REC-1];

	// Pixel indices whose output is still due
	int exp_q[$];
	int layer_cnt     = 0;
	int samples_total = 0;

	squeeze_top squeeze_top_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.en           (en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.ofm          (ofm),
		.sample       (sample),
		.finish       (finish)
	);

	//////////////////////////////////////////////////
	// Error reporting
	//////////////////////////////////////////////////
	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		stop_with_failure($sformatf("ERR %0t ns: %s got 0x%0h expected 0x%0h",
			$time, name, got, exp));
	endtask

	//////////////////////////////////////////////////
	// Clock and watchdog
	//////////////////////////////////////////////////
	initial begin : clock_gen
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	initial begin : watchdog
		#(TIMEOUT_CYC * CLK_PERIOD);
		stop_with_failure("Watchdog expired before the test sequence completed");
	end

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////
	// Ten cycles low, inputs parked
	task automatic apply_reset();
		@(posedge clk);
		#1;
		arst_n       = 1'b0;
		en           = 1'b0;
		ifm          = '0;
		ram_feedback = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;
	endtask

	// en low, nothing may come out
	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#1;
			assert (sample === 1'b0) else report_mismatch("sample", sample, 0);
			assert (finish === 1'b0) else report_mismatch("finish", finish, 0);
		end
	endtask

	// One full map, channel by channel
	task automatic stream_layer(input bit with_gaps);
		int gap;
		for (int p = 0; p < NPIX; p++) begin
			for (int c = 0; c < `SQZ_CHIN; c++) begin
				gap = with_gaps ? int'($urandom % (MAX_GAP + 1)) : 0;
				// Junk on ifm during a pause must be ignored
				repeat (gap) begin
					@(posedge clk);
					#1;
					en  = 1'b0;
					ifm = pix_t'($urandom);
				end
				@(posedge clk);
				#1;
				en  = 1'b1;
				ifm = pix_t'(trace_mem[p * REC + c]);
				if (c == `SQZ_CHIN - 1) begin
					exp_q.push_back(p);
				end
			end
		end
		@(posedge clk);
		#1;
		en  = 1'b0;
		ifm = '0;
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	// Flag up after the last strobe, one ack pulse clears it for good
	task automatic check_layer_done();
		@(posedge clk);
		#1;
		assert (finish === 1'b1) else report_mismatch("finish", finish, 1);
		repeat (5) begin
			@(posedge clk);
			#1;
			assert (finish === 1'b1) else report_mismatch("finish", finish, 1);
		end
		ram_feedback = 1'b1;
		@(posedge clk);
		#1;
		ram_feedback = 1'b0;
		repeat (10) begin
			assert (finish === 1'b0) else report_mismatch("finish", finish, 0);
			@(posedge clk);
			#1;
		end
	endtask

	//////////////////////////////////////////////////
	// Output checker
	//////////////////////////////////////////////////
	// Negedge sampling, outputs settled since the rising edge
	always @(negedge clk) begin : check_outputs
		int p;
		if (!arst_n) begin
			layer_cnt = 0;
		end else begin
			if (sample === 1'b1) begin
				assert (exp_q.size() > 0 && layer_cnt < NPIX)
				else stop_with_failure("Sample strobe arrived with no pixel pending");
				p = exp_q.pop_front();
				for (int l = 0; l < `SQZ_LANES; l++) begin
					assert (ofm[l] === pix_t'(trace_mem[p * REC + `SQZ_CHIN + l]))
					else report_mismatch($sformatf("ofm[%0d]", l), ofm[l],
						trace_mem[p * REC + `SQZ_CHIN + l]);
				end
				layer_cnt++;
				samples_total++;
			end
			// Done flag stays low until the whole map is out
			if (layer_cnt < NPIX) begin
				assert (finish === 1'b0) else report_mismatch("finish", finish, 0);
			end
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin : main_seq
		void'($urandom(32'h4e4e));
		arst_n       = 1'b0;
		en           = 1'b0;
		ifm          = '0;
		ram_feedback = 1'b0;
		$readmemh("sim/squeeze_trace.txt", trace_mem);
		assert ((^trace_mem[NPIX*REC-1]) !== 1'bx)
		else stop_with_failure("Trace file sim/squeeze_trace.txt missing or too short");

		// Layer one, back to back channels
		apply_reset();
		check_idle(20);
		stream_layer(1'b0);
		wait_drained();
		check_layer_done();
		check_idle(10);

		// Layer two, random pauses between channels
		apply_reset();
		check_idle(20);
		stream_layer(1'b1);
		wait_drained();
		check_layer_done();
		check_idle(20);

		if (samples_total == 2 * NPIX && exp_q.size() == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			stop_with_failure($sformatf("Saw %0d samples, expected %0d",
				samples_total, 2 * NPIX));
		end
	end

endmodule

//--- vlog.f
+incdir+design
design/squeeze_pkg.sv
design/coef_rom.sv
design/mac_lane.sv
design/requant.sv
design/squeeze_ctrl.sv
design/squeeze_top.sv
sim/tb_squeeze.sv
